//--- all.f
mips_pkg.sv
alu_control.sv
forward_unit.sv
alu.sv
ex_mem_reg.sv
ex_stage.sv
tb_ex_stage.sv

//--- Makefile
.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f all.f --top-module tb_ex_stage -o tb_ex_stage
	@out="$$(./obj_dir/tb_ex_stage)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL TESTS PASSED"

lint:
	verilator --lint-only --timing -Wall -f all.f --top-module tb_ex_stage

clean:
	rm -rf obj_dir

//--- tb_ex_stage.sv
// Directed testbench for the execute stage, model based checks of the EX/MEM register
module tb_ex_stage import mips_pkg::*; ();

	localparam int MAX_CYCLES = 400;   // Tests take about 90 cycles, ample margin

	// All DUT inputs except clock and reset, driven as one bundle
	typedef struct packed {
		ex_ctrl_t          ex;
		m_ctrl_t           m;
		wb_ctrl_t          wb;
		logic [REG_W-1:0]  rs;
		logic [REG_W-1:0]  rt;
		logic [REG_W-1:0]  rd;
		logic [DATA_W-1:0] rs_data;
		logic [DATA_W-1:0] rt_data;
		logic [DATA_W-1:0] imm;
		wb_ctrl_t          mem_wb;
		logic [REG_W-1:0]  mem_rd;
		logic [DATA_W-1:0] mem_res;
		wb_ctrl_t          wb_wb;
		logic [REG_W-1:0]  wb_rd;
		logic [DATA_W-1:0] wb_data;
	} stim_t;

	logic    clk;
	logic    reset;
	stim_t   stim;
	ex_mem_t ex_mem;

	logic [31:0] seed = 32'hfa60;
	int          errors = 0;
	int          checks = 0;
	int          tests_run = 0;
	int          tests_failed = 0;
	int          test_mark = 0;      // Error count at start of current test
	int          cycles = 0;
	ex_mem_t     pending;            // Expected output of the last instruction sent
	logic        pending_valid = 1'b0;

	ex_stage ex_stage_inst (
		.clk     (clk),
		.reset   (reset),
		.ex      (stim.ex),
		.m       (stim.m),
		.wb      (stim.wb),
		.rs      (stim.rs),
		.rt      (stim.rt),
		.rd      (stim.rd),
		.rs_data (stim.rs_data),
		.rt_data (stim.rt_data),
		.imm     (stim.imm),
		.mem_wb  (stim.mem_wb),
		.mem_rd  (stim.mem_rd),
		.mem_res (stim.mem_res),
		.wb_wb   (stim.wb_wb),
		.wb_rd   (stim.wb_rd),
		.wb_data (stim.wb_data),
		.ex_mem  (ex_mem)
	);

	always #20 clk = ~clk;   // Period 40

	// Hard stop if a test never returns
	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout: run went past %0d cycles without finishing", MAX_CYCLES);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	// ------------------------------
	// Reference model
	// ------------------------------
	function automatic logic [31:0] next_rand();
		seed = seed * 32'd1664525 + 32'd1013904223;   // Numerical Recipes LCG
		return seed;
	endfunction

	// Newest producer of register r, MEM before WB, $zero never
	function automatic logic [31:0] operand_value(input stim_t s, input logic [4:0] r,
			input logic [31:0] from_regfile);
		if (s.mem_wb.reg_write && s.mem_rd != 5'd0 && s.mem_rd == r)
			return s.mem_res;
		if (s.wb_wb.reg_write && s.wb_rd != 5'd0 && s.wb_rd == r)
			return s.wb_data;
		return from_regfile;
	endfunction

	function automatic ex_mem_t model(input stim_t s);
		ex_mem_t     e;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] store;
		logic [31:0] r;
		a = operand_value(s, s.rs, s.rs_data);
		store = operand_value(s, s.rt, s.rt_data);
		b = s.ex.alu_src ? s.imm : store;
		case (s.ex.alu_op)
			ALU_OP_ADD: r = a + b;
			ALU_OP_SUB: r = a - b;
			ALU_OP_RTYPE: begin
				case (s.imm[5:0])
					FN_ADD:  r = a + b;
					FN_SUB:  r = a - b;
					FN_AND:  r = a & b;
					FN_OR:   r = a | b;
					FN_NOR:  r = ~(a | b);
					FN_SLT:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					default: r = 32'd0;   // Unsupported funct
				endcase
			end
			default: r = 32'd0;
		endcase
		e.m = s.m;
		e.wb = s.wb;
		e.res = r;
		e.zero = (r == 32'd0);
		e.write_data = store;
		e.write_register = s.ex.reg_dst ? s.rd : s.rt;
		return e;
	endfunction

	// ------------------------------
	// Stimulus builders
	// ------------------------------
	function automatic logic [5:0] pick_funct(input logic [2:0] idx);
		case (idx)
			3'd0: return FN_ADD;
			3'd1: return FN_SUB;
			3'd2: return FN_AND;
			3'd3: return FN_OR;
			3'd4: return FN_SLT;
			3'd5: return FN_NOR;
			default: return 6'd8;   // jr, not an ALU op
		endcase
	endfunction

	// Register numbers kept in 0..7 so forwarding hits are frequent
	function automatic stim_t random_stim();
		stim_t       s;
		logic [31:0] r;
		logic [31:0] r2;
		r = next_rand();
		r2 = next_rand();
		s.ex = ex_ctrl_t'(r[3:0]);
		s.m = m_ctrl_t'(r[6:4]);
		s.wb = wb_ctrl_t'(r[8:7]);
		s.rs = {2'b00, r[11:9]};
		s.rt = {2'b00, r[14:12]};
		s.rd = r[19:15];
		s.mem_wb = wb_ctrl_t'(r[21:20]);
		s.mem_rd = {2'b00, r[24:22]};
		s.wb_wb = wb_ctrl_t'(r[26:25]);
		s.wb_rd = {2'b00, r[29:27]};
		s.imm = {r2[31:6], pick_funct(r2[2:0])};
		s.rs_data = next_rand();
		s.rt_data = next_rand();
		s.mem_res = next_rand();
		s.wb_data = next_rand();
		return s;
	endfunction

	// Plain ALU instruction, no forwarding sources active
	function automatic stim_t alu_stim(input logic [1:0] op, input logic [5:0] funct,
			input logic [31:0] a, input logic [31:0] b);
		stim_t s;
		s = '0;
		s.ex.reg_dst = 1'b1;
		s.ex.alu_op = op;
		s.wb.reg_write = 1'b1;
		s.rs = 5'd1;
		s.rt = 5'd2;
		s.rd = 5'd3;
		s.rs_data = a;
		s.rt_data = b;
		s.imm = {26'd0, funct};
		return s;
	endfunction

	// ------------------------------
	// Checking
	// ------------------------------
	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic compare_ex_mem(input ex_mem_t exp);
		check("ex_mem.m", {29'd0, ex_mem.m}, {29'd0, exp.m});
		check("ex_mem.wb", {30'd0, ex_mem.wb}, {30'd0, exp.wb});
		check("ex_mem.res", ex_mem.res, exp.res);
		check("ex_mem.zero", {31'd0, ex_mem.zero}, {31'd0, exp.zero});
		check("ex_mem.write_data", ex_mem.write_data, exp.write_data);
		check("ex_mem.write_register", {27'd0, ex_mem.write_register},
			{27'd0, exp.write_register});
	endtask

	// Drive one instruction, check the previous one once it is registered
	task automatic send(input stim_t s);
		@(posedge clk);
		stim <= s;
		@(negedge clk);
		if (pending_valid)
			compare_ex_mem(pending);
		pending = model(s);
		pending_valid = 1'b1;
	endtask

	task automatic end_test(input string name);
		if (pending_valid) begin
			@(posedge clk);
			@(negedge clk);
			compare_ex_mem(pending);   // Last instruction of the test
			pending_valid = 1'b0;
		end
		tests_run++;
		if (errors == test_mark) begin
			$display("test %0d %s: ok", tests_run, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: %0d mismatches", tests_run, name, errors - test_mark);
		end
		test_mark = errors;
	endtask

	// ------------------------------
	// Tests
	// ------------------------------
	task automatic test_reset();
		stim_t busy;
		busy = random_stim();
		busy.m = 3'b111;       // Every write enable set while in reset
		busy.wb = 2'b11;
		@(posedge clk);
		stim <= busy;
		repeat (3) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		compare_ex_mem(ex_mem_t'('0));
		end_test("reset");
	endtask

	task automatic test_rtype();
		logic [5:0] fns [7] = '{FN_ADD, FN_SUB, FN_AND, FN_OR, FN_SLT, FN_NOR, 6'd8};
		for (int i = 0; i < 7; i++)
			send(alu_stim(ALU_OP_RTYPE, fns[i], next_rand(), next_rand()));
		end_test("rtype");
	endtask

	task automatic test_itype();
		stim_t s;
		for (int i = 0; i < 8; i++) begin
			s = random_stim();
			s.mem_wb = '0;        // No forwarding here
			s.wb_wb = '0;
			s.ex.alu_src = 1'b1;
			s.ex.alu_op = (i < 3) ? ALU_OP_ADD : (i < 7) ? ALU_OP_SUB : 2'd3;
			s.ex.reg_dst = i[0];
			s.m = i[1] ? 3'b010 : 3'b001;   // Load or store
			send(s);
		end
		end_test("itype");
	endtask

	// Even cases hit rs, odd cases hit rt
	task automatic test_forward();
		stim_t      s;
		logic [4:0] tgt;
		for (int i = 0; i < 10; i++) begin
			s = alu_stim(ALU_OP_RTYPE, FN_ADD, next_rand(), next_rand());
			s.rs = 5'd5;
			s.rt = 5'd6;
			s.mem_rd = 5'd9;
			s.wb_rd = 5'd10;
			s.mem_res = next_rand();
			s.wb_data = next_rand();
			tgt = i[0] ? s.rt : s.rs;
			case (i / 2)
				0: begin
					s.mem_wb.reg_write = 1'b1;
					s.mem_rd = tgt;
				end
				1: begin
					s.wb_wb.reg_write = 1'b1;
					s.wb_rd = tgt;
				end
				2: begin                       // Both match, MEM must win
					s.mem_wb.reg_write = 1'b1;
					s.wb_wb.reg_write = 1'b1;
					s.mem_rd = tgt;
					s.wb_rd = tgt;
				end
				3: begin                       // $zero as operand and destination
					if (i[0])
						s.rt = 5'd0;
					else
						s.rs = 5'd0;
					s.mem_wb.reg_write = 1'b1;
					s.wb_wb.reg_write = 1'b1;
					s.mem_rd = 5'd0;
					s.wb_rd = 5'd0;
				end
				default: begin                 // Numbers match, reg_write low
					s.mem_wb.mem_to_reg = 1'b1;
					s.mem_rd = tgt;
					s.wb_rd = tgt;
				end
			endcase
			send(s);
		end
		end_test("forward");
	endtask

	task automatic test_stream();
		for (int i = 0; i < 40; i++)
			send(random_stim());
		end_test("stream");
	endtask

	task automatic test_slt_zero();
		send(alu_stim(ALU_OP_RTYPE, FN_SLT, 32'hffff_fffb, 32'd3));   // -5 < 3
		send(alu_stim(ALU_OP_RTYPE, FN_SLT, 32'd3, 32'hffff_fffb));
		send(alu_stim(ALU_OP_RTYPE, FN_SLT, 32'h8000_0000, 32'h7fff_ffff));
		send(alu_stim(ALU_OP_RTYPE, FN_SUB, 32'hdead_beef, 32'hdead_beef));
		send(alu_stim(ALU_OP_SUB, 6'd0, 32'd77, 32'd77));   // beq taken
		send(alu_stim(ALU_OP_SUB, 6'd0, 32'd77, 32'd78));
		end_test("slt_zero");
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		stim = '0;
		test_reset();
		test_rtype();
		test_itype();
		test_forward();
		test_stream();
		test_slt_zero();
		$display("%0d tests, %0d failed, %0d checks, %0d mismatches",
			tests_run, tests_failed, checks, errors);
		if (errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

//--- ex_stage.sv
// Execute stage top, forwarding, ALU decode, ALU and EX/MEM register
module ex_stage import mips_pkg::*; (
	input  logic              clk,
	input  logic              reset,
	// ID/EX values
	input  ex_ctrl_t          ex,
	input  m_ctrl_t           m,
	input  wb_ctrl_t          wb,
	input  logic [REG_W-1:0]  rs,
	input  logic [REG_W-1:0]  rt,
	input  logic [REG_W-1:0]  rd,
	input  logic [DATA_W-1:0] rs_data,
	input  logic [DATA_W-1:0] rt_data,
	input  logic [DATA_W-1:0] imm,
	// Forwarding sources
	input  wb_ctrl_t          mem_wb,
	input  logic [REG_W-1:0]  mem_rd,
	input  logic [DATA_W-1:0] mem_res,
	input  wb_ctrl_t          wb_wb,
	input  logic [REG_W-1:0]  wb_rd,
	input  logic [DATA_W-1:0] wb_data,
	output ex_mem_t           ex_mem
);

	logic [DATA_W-1:0] op_a;
	logic [DATA_W-1:0] fwd_b;      // Forwarded rt, ALU B and store data
	alu_ctrl_t         alu_ctrl;
	logic [DATA_W-1:0] res;
	logic              zero;

	// ------------------------------
	// Forwarding and decode
	// ------------------------------
	forward_unit forward_unit_inst (
		.clk     (clk),
		.rs      (rs),
		.rt      (rt),
		.rs_data (rs_data),
		.rt_data (rt_data),
		.mem_wb  (mem_wb),
		.mem_rd  (mem_rd),
		.mem_res (mem_res),
		.wb_wb   (wb_wb),
		.wb_rd   (wb_rd),
		.wb_data (wb_data),
		.op_a    (op_a),
		.fwd_b   (fwd_b)
	);

	alu_control alu_control_inst (
		.clk      (clk),
		.alu_op   (ex.alu_op),
		.funct    (imm[5:0]),    // funct sits in the low immediate bits
		.alu_ctrl (alu_ctrl)
	);

	// ------------------------------
	// Compute and register
	// ------------------------------
	alu alu_inst (
		.op_a     (op_a),
		.fwd_b    (fwd_b),
		.imm      (imm),
		.alu_src  (ex.alu_src),
		.alu_ctrl (alu_ctrl),
		.res      (res),
		.zero     (zero)
	);

	ex_mem_reg ex_mem_reg_inst (
		.clk        (clk),
		.reset      (reset),
		.reg_dst    (ex.reg_dst),
		.rt         (rt),
		.rd         (rd),
		.m          (m),
		.wb         (wb),
		.res        (res),
		.zero       (zero),
		.store_data (fwd_b),
		.ex_mem     (ex_mem)
	);

endmodule

//--- ex_mem_reg.sv
// EX/MEM pipeline register with destination register select
module ex_mem_reg import mips_pkg::*; (
	input  logic              clk,
	input  logic              reset,
	input  logic              reg_dst,      // 1 = rd, 0 = rt
	input  logic [REG_W-1:0]  rt,
	input  logic [REG_W-1:0]  rd,
	input  m_ctrl_t           m,
	input  wb_ctrl_t          wb,
	input  logic [DATA_W-1:0] res,
	input  logic              zero,
	input  logic [DATA_W-1:0] store_data,
	output ex_mem_t           ex_mem
);

	logic [REG_W-1:0] dest;     // Selected destination
	ex_mem_t          ex_mem_d; // Next register value

	// R-type writes rd, I-type writes rt
	assign dest = reg_dst ? rd : rt;

	// ------------------------------
	// Payload assembly
	// ------------------------------
	always_comb begin
		ex_mem_d.m              = m;          // MEM control passes through
		ex_mem_d.wb             = wb;         // WB control passes through
		ex_mem_d.res            = res;
		ex_mem_d.zero           = zero;
		ex_mem_d.write_data     = store_data;
		ex_mem_d.write_register = dest;
	end

	// ------------------------------
	// Register, one cycle latency
	// ------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			ex_mem <= '0;       // No write can leak out of reset
		end else begin
			ex_mem <= ex_mem_d;
		end
	end

	// Control bits must be quiet the cycle after reset
	a_reset_ctrl: assert property (
		@(posedge clk) reset |=> (ex_mem.m == '0) && (ex_mem.wb == '0)
	) else $error("EX/MEM control not cleared by reset");

endmodule

//--- alu.sv
// 32-bit ALU with operand B select and zero flag
module alu import mips_pkg::*; (
	input  logic [DATA_W-1:0] op_a,
	input  logic [DATA_W-1:0] fwd_b,
	input  logic [DATA_W-1:0] imm,       // Sign extended immediate
	input  logic              alu_src,   // 1 = immediate on B
	input  alu_ctrl_t         alu_ctrl,
	output logic [DATA_W-1:0] res,
	output logic              zero
);

	logic [DATA_W-1:0] op_b;
	logic              a_lt_b;   // Signed compare for SLT

	// ------------------------------
	// Operand B select
	// ------------------------------
	assign op_b = alu_src ? imm : fwd_b;

	// Signed, so -1 < 1 holds
	assign a_lt_b = $signed(op_a) < $signed(op_b);

	// ------------------------------
	// Operation
	// ------------------------------
	always_comb begin
		case (alu_ctrl)
			ALU_ADD: res = op_a + op_b;       // Wraps, no overflow trap
			ALU_SUB: res = op_a - op_b;
			ALU_AND: res = op_a & op_b;
			ALU_OR:  res = op_a | op_b;
			ALU_SLT: res = {{(DATA_W-1){1'b0}}, a_lt_b};
			ALU_NOR: res = ~(op_a | op_b);
			ALU_BAD: res = '0;                // Unsupported op
			default: res = '0;
		endcase
	end

	// Zero flag straight from the result, beq uses it after SUB
	assign zero = (res == '0);

endmodule

//--- forward_unit.sv
// Operand forwarding from the MEM and WB stages into the ALU inputs
module forward_unit import mips_pkg::*; (
	input  logic              clk,        // Assertion sampling only
	input  logic [REG_W-1:0]  rs,
	input  logic [REG_W-1:0]  rt,
	input  logic [DATA_W-1:0] rs_data,
	input  logic [DATA_W-1:0] rt_data,
	// MEM stage source, one instruction ahead
	input  wb_ctrl_t          mem_wb,
	input  logic [REG_W-1:0]  mem_rd,
	input  logic [DATA_W-1:0] mem_res,
	// WB stage source, two instructions ahead
	input  wb_ctrl_t          wb_wb,
	input  logic [REG_W-1:0]  wb_rd,
	input  logic [DATA_W-1:0] wb_data,
	output logic [DATA_W-1:0] op_a,
	output logic [DATA_W-1:0] fwd_b       // Also used as store data
);

	logic mem_hit_a, wb_hit_a;
	logic mem_hit_b, wb_hit_b;

	// Source writes a nonzero register that matches the operand
	function automatic logic src_hit(
		input wb_ctrl_t         src,
		input logic [REG_W-1:0] src_rd,
		input logic [REG_W-1:0] r
	);
		return src.reg_write && (src_rd != '0) && (src_rd == r);
	endfunction

	assign mem_hit_a = src_hit(mem_wb, mem_rd, rs);
	assign wb_hit_a  = src_hit(wb_wb, wb_rd, rs);
	assign mem_hit_b = src_hit(mem_wb, mem_rd, rt);
	assign wb_hit_b  = src_hit(wb_wb, wb_rd, rt);

	// ------------------------------
	// Operand muxes, MEM first
	// ------------------------------
	always_comb begin
		if (mem_hit_a)
			op_a = mem_res;          // Newest value
		else if (wb_hit_a)
			op_a = wb_data;
		else
			op_a = rs_data;          // Register file value
	end

	always_comb begin
		if (mem_hit_b)
			fwd_b = mem_res;
		else if (wb_hit_b)
			fwd_b = wb_data;
		else
			fwd_b = rt_data;
	end

	// $zero is hardwired, nothing may be forwarded into it
	a_no_fwd_zero: assert property (
		@(posedge clk) ((rs == '0) |-> (op_a == rs_data)) and ((rt == '0) |-> (fwd_b == rt_data))
	) else $error("forwarding into register 0");

	// Younger producer in MEM must beat the older one in WB
	a_mem_wins: assert property (
		@(posedge clk) ((mem_hit_a && wb_hit_a) |-> (op_a == mem_res))
			and ((mem_hit_b && wb_hit_b) |-> (fwd_b == mem_res))
	) else $error("WB value forwarded over MEM value");

endmodule

//--- alu_control.sv
// ALU control decoder, maps alu_op and the funct field to an ALU code
module alu_control import mips_pkg::*; (
	input  logic       clk,       // Assertion sampling only
	input  logic [1:0] alu_op,
	input  logic [5:0] funct,
	output alu_ctrl_t  alu_ctrl
);

	alu_ctrl_t funct_ctrl;  // Decode of funct alone

	// ------------------------------
	// Funct field decode
	// ------------------------------
	always_comb begin
		case (funct)
			FN_ADD:  funct_ctrl = ALU_ADD;
			FN_SUB:  funct_ctrl = ALU_SUB;
			FN_AND:  funct_ctrl = ALU_AND;
			FN_OR:   funct_ctrl = ALU_OR;
			FN_SLT:  funct_ctrl = ALU_SLT;   // Signed set on less than
			FN_NOR:  funct_ctrl = ALU_NOR;
			default: funct_ctrl = ALU_BAD;   // Shifts, jr etc. not handled here
		endcase
	end

	// ------------------------------
	// Operation class select
	// ------------------------------
	always_comb begin
		case (alu_op)
			ALU_OP_ADD:   alu_ctrl = ALU_ADD;      // Address calc
			ALU_OP_SUB:   alu_ctrl = ALU_SUB;      // beq compare
			ALU_OP_RTYPE: alu_ctrl = funct_ctrl;
			default:      alu_ctrl = ALU_BAD;      // alu_op 3 unused
		endcase
	end

	// Known class must always give a known code, even for odd funct values
	a_ctrl_known: assert property (
		@(posedge clk) !$isunknown(alu_op) && (alu_op != ALU_OP_RTYPE || !$isunknown(funct))
			|-> !$isunknown(alu_ctrl)
	) else $error("alu_ctrl unknown for alu_op %0d funct %0d", alu_op, funct);

endmodule

//--- mips_pkg.sv
// MIPS execute stage shared types, control codes and widths
package mips_pkg;

	// ------------------------------
	// Widths
	// ------------------------------
	localparam int DATA_W = 32;     // Datapath width
	localparam int REG_W  = 5;      // Register number width

	// ------------------------------
	// ALU operation classes
	// ------------------------------
	localparam logic [1:0] ALU_OP_ADD   = 2'd0; // Loads and stores
	localparam logic [1:0] ALU_OP_SUB   = 2'd1; // Branch compare
	localparam logic [1:0] ALU_OP_RTYPE = 2'd2; // Operation comes from funct

	// R-type funct field codes
	localparam logic [5:0] FN_ADD = 6'd32;
	localparam logic [5:0] FN_SUB = 6'd34;
	localparam logic [5:0] FN_AND = 6'd36;
	localparam logic [5:0] FN_OR  = 6'd37;
	localparam logic [5:0] FN_NOR = 6'd39;
	localparam logic [5:0] FN_SLT = 6'd42;

	// ALU control codes seen by the ALU
	typedef enum logic [3:0] {
		ALU_ADD = 4'b0000,
		ALU_SUB = 4'b0001,
		ALU_AND = 4'b0010,
		ALU_OR  = 4'b0011,
		ALU_SLT = 4'b0111,
		ALU_NOR = 4'b1001,
		ALU_BAD = 4'b1111   // Unknown funct or alu_op
	} alu_ctrl_t;

	// ------------------------------
	// Pipeline control groups
	// ------------------------------
	typedef struct packed {
		logic       reg_dst;    // 1 = rd, 0 = rt
		logic [1:0] alu_op;
		logic       alu_src;    // 1 = immediate
	} ex_ctrl_t;

	typedef struct packed {
		logic branch;
		logic mem_read;
		logic mem_write;
	} m_ctrl_t;

	typedef struct packed {
		logic reg_write;
		logic mem_to_reg;
	} wb_ctrl_t;

	// EX/MEM register contents
	typedef struct packed {
		m_ctrl_t             m;
		wb_ctrl_t            wb;
		logic [DATA_W-1:0]   res;
		logic                zero;
		logic [DATA_W-1:0]   write_data;     // Forwarded rt as store data
		logic [REG_W-1:0]    write_register;
	} ex_mem_t;

endpackage
